//--- Bender.yml
package:
  name: cache

sources:
  - hdl/cache_pkg.sv
  - hdl/cache_ctrl_if.sv
  - hdl/cache_control.sv
  - hdl/cache_datapath.sv
  - hdl/pmem_port.sv
  - hdl/cache.sv
  - target: test
    files:
      - bench/pmem_model.sv
      - bench/cache_asserts.sv
      - bench/tb_cache.sv

//--- bench/cache_asserts.sv
`timescale 1ns/1ps

module cache_asserts (
    input logic                   clk,
    input logic                   arst_n,
    input cache_pkg::ctrl_state_e state,
    input logic                   mem_read,
    input logic                   mem_write,
    input logic                   mem_cancel,
    input logic                   mem_resp,
    input logic                   hit,
    input logic                   pmem_read,
    input logic                   pmem_write
);

    import cache_pkg::*;

    int fails = 0;

    resp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        mem_resp |=> !mem_resp)
        else begin
            $error("mem_resp held longer than one cycle");
            fails++;
        end

    // one memory transaction at a time.
    mem_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(pmem_read && pmem_write))
        else begin
            $error("pmem_read and pmem_write high in the same cycle");
            fails++;
        end

    hit_in_one: assert property (@(posedge clk) disable iff (!arst_n)
        (state == idle && (mem_read || mem_write) && !mem_cancel) ##1 (hit && !mem_cancel)
        |-> mem_resp)
        else begin
            $error("hit not answered one cycle after idle");
            fails++;
        end

endmodule : cache_asserts

bind cache cache_asserts u_asserts (
    .clk        (clk),
    .arst_n     (arst_n),
    .state      (u_control.state),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_cancel (mem_cancel),
    .mem_resp   (mem_resp),
    .hit        (ctl_if.hit),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write)
);

//--- bench/cache_trace.txt
# op address byte_enable write_word reads writes writeback_address
# R read, W write, C read cancelled while memory is busy; write_word repeats across the line
R 00000060 00000000 00000000 1 0 00000000
R 00000060 00000000 00000000 0 0 00000000
W 00000064 000000f0 a5a55a5a 0 0 00000000
R 00000060 00000000 00000000 0 0 00000000
R 00000260 00000000 00000000 1 0 00000000
R 00000460 00000000 00000000 1 1 00000060
R 00000060 00000000 00000000 1 0 00000000
W 00000260 ffffffff 12345678 1 0 00000000
W 00000660 0000000f deadbeef 1 0 00000000
R 00000460 00000000 00000000 1 1 00000260
C 00000080 00000000 00000000 1 0 00000000
R 00000080 00000000 00000000 0 0 00000000
W 00000084 0000ff00 cafef00d 0 0 00000000
R 00000080 00000000 00000000 0 0 00000000
R 00000660 00000000 00000000 0 0 00000000
R 00000860 00000000 00000000 1 0 00000000
R 00000a60 00000000 00000000 1 1 00000660

//--- bench/pmem_model.sv
`timescale 1ns/1ps

module pmem_model (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [31:0]      pmem_address,
    input  logic             pmem_read,
    input  logic             pmem_write,
    input  cache_pkg::line_t pmem_wdata,
    output cache_pkg::line_t pmem_rdata,
    output logic             pmem_resp
);

    import cache_pkg::*;

    localparam logic [31:0] seed = 32'h768b_cede;

    line_t       mem [logic [31:0]];
    int          wait_cnt;
    int          reads;
    int          writes;
    logic [31:0] wr_addr;   // last writeback.
    line_t       wr_line;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // untouched lines, keyed by line address.
    function automatic line_t seed_line(input logic [31:0] line_addr);
        logic [31:0] x;
        line_t       l;
        x = seed ^ line_addr;
        for (int w = 0; w < 8; w++) begin
            x = xorshift32(x);
            l[32*w +: 32] = x;
        end
        return l;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
            wait_cnt = 0;
            reads    = 0;
            writes   = 0;
        end else begin
            pmem_resp <= 1'b0;
            if ((pmem_read || pmem_write) && !pmem_resp) begin
                if (wait_cnt < 2) begin
                    wait_cnt++;
                end else begin
                    wait_cnt = 0;
                    pmem_resp <= 1'b1;   // third cycle of the request.
                    if (pmem_read) begin
                        if (mem.exists(pmem_address)) pmem_rdata <= mem[pmem_address];
                        else pmem_rdata <= seed_line(pmem_address);
                        reads++;
                    end else begin
                        mem[pmem_address] = pmem_wdata;
                        wr_addr = pmem_address;
                        wr_line = pmem_wdata;
                        writes++;
                    end
                end
            end
        end
    end

endmodule : pmem_model

//--- bench/tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

    import cache_pkg::*;

    localparam string trace_file  = "bench/cache_trace.txt";
    localparam int    hit_latency = 2;   // drive edge to response, in cycles.

    typedef struct {
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] word;
        int          reads;
        int          writes;
        logic [31:0] wb_addr;
    } trace_op_t;

    logic        clk;
    logic        arst_n;
    logic [31:0] mem_address;
    logic        mem_read;
    logic        mem_write;
    logic        mem_cancel;
    logic [31:0] mem_byte_enable;
    line_t       mem_rdata;
    line_t       mem_wdata;
    logic        mem_resp;
    logic [31:0] pmem_address;
    logic        pmem_read;
    logic        pmem_write;
    line_t       pmem_rdata;
    line_t       pmem_wdata;
    logic        pmem_resp;

    trace_op_t trace [$];
    line_t     shadow [logic [31:0]];   // cpu view of memory.
    int        errors;
    int        checks;
    int        cycles;
    int        limit;

    cache u_dut (.*);

    pmem_model u_mem (
        .clk          (clk),
        .arst_n       (arst_n),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles, the cache stopped answering", cycles);
        $display("Some tests failed");
        $finish;
    end

    function automatic line_t shadow_line(input logic [31:0] line_addr);
        if (shadow.exists(line_addr)) return shadow[line_addr];
        return u_mem.seed_line(line_addr);
    endfunction

    function automatic line_t merge_bytes(input line_t old, input logic [31:0] be,
                                          input logic [31:0] word);
        line_t wide;
        line_t res;
        wide = {8{word}};
        for (int b = 0; b < 32; b++) begin
            res[8*b +: 8] = be[b] ? wide[8*b +: 8] : old[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_line(input line_t got, input line_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_trace();
        int        fd;
        int        n;
        string     text;
        trace_op_t t;
        fd = $fopen(trace_file, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", trace_file);
            errors++;
            return;
        end
        while ($fgets(text, fd) > 0) begin
            n = $sscanf(text, "%c %h %h %h %d %d %h", t.op, t.addr, t.be, t.word,
                        t.reads, t.writes, t.wb_addr);
            if (n == 7 && t.op != "#") trace.push_back(t);
        end
        $fclose(fd);
    endtask

    task automatic run_op(input int num, input trace_op_t t);
        int          reads0;
        int          writes0;
        int          errors0;
        int          latency;
        bit          got_resp;
        line_t       got;
        logic [31:0] line_addr;
        reads0    = u_mem.reads;
        writes0   = u_mem.writes;
        errors0   = errors;
        latency   = 0;
        got_resp  = 1'b0;
        line_addr = {t.addr[31:5], 5'b0};
        @(posedge clk);
        mem_address     <= t.addr;
        mem_byte_enable <= t.be;
        mem_wdata       <= {8{t.word}};
        mem_read        <= (t.op != "W");
        mem_write       <= (t.op == "W");
        if (t.op == "C") begin
            @(negedge clk);
            while (!pmem_read && !pmem_write) begin
                got_resp |= mem_resp;
                @(negedge clk);
            end
            @(posedge clk);
            mem_cancel <= 1'b1;
            mem_read   <= 1'b0;
            @(posedge clk);
            mem_cancel <= 1'b0;
            @(negedge clk);
            // memory finishes, then done and refill_done.
            while (pmem_read || pmem_write ||
                   u_mem.reads + u_mem.writes < reads0 + writes0 + t.reads + t.writes) begin
                got_resp |= mem_resp;
                @(negedge clk);
            end
            repeat (4) begin
                got_resp |= mem_resp;
                @(negedge clk);
            end
            if (got_resp) begin
                $display("cancelled request at %h still got a response", t.addr);
                errors++;
            end
        end else begin
            do begin
                @(negedge clk);
                latency++;
            end while (!mem_resp);
            got = mem_rdata;
            @(posedge clk);
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end
        check_count(u_mem.reads - reads0, t.reads, "memory reads");
        check_count(u_mem.writes - writes0, t.writes, "memory writes");
        if (t.writes > 0) begin
            check_addr(u_mem.wr_addr, t.wb_addr, "writeback address");
            check_line(u_mem.wr_line, shadow_line(t.wb_addr), "writeback line");
        end
        if (t.op != "C" && t.reads == 0 && t.writes == 0) begin
            check_count(latency, hit_latency, "hit latency");
        end
        if (t.op == "R") check_line(got, shadow_line(line_addr), "read line");
        if (t.op == "W") shadow[line_addr] = merge_bytes(shadow_line(line_addr), t.be, t.word);
        $display("test %0d %c %h: %s", num, t.op, t.addr, (errors == errors0) ? "ok" : "failed");
    endtask

    initial begin
        int asserts_failed;
        errors          = 0;
        checks          = 0;
        limit           = 0;
        arst_n          = 1'b0;
        mem_address     = '0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_cancel      = 1'b0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        load_trace();
        limit = (trace.size() + 1) * 40;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        foreach (trace[i]) run_op(i, trace[i]);
        asserts_failed = u_dut.u_asserts.fails;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 trace.size(), checks, errors, asserts_failed);
        if (errors == 0 && asserts_failed == 0 && trace.size() > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_cache

//--- cache.f
hdl/cache_pkg.sv
hdl/cache_ctrl_if.sv
hdl/cache_control.sv
hdl/cache_datapath.sv
hdl/pmem_port.sv
hdl/cache.sv
bench/pmem_model.sv
bench/cache_asserts.sv
bench/tb_cache.sv

//--- hdl/cache.sv
`timescale 1ns/1ps

module cache (
    input  logic               clk,
    input  logic               arst_n,

    // cpu side.
    input  logic [31:0]        mem_address,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               mem_cancel,
    input  logic [31:0]        mem_byte_enable,
    output cache_pkg::line_t   mem_rdata,
    input  cache_pkg::line_t   mem_wdata,
    output logic               mem_resp,

    // memory side.
    output logic [31:0]        pmem_address,
    output logic               pmem_read,
    output logic               pmem_write,
    input  cache_pkg::line_t   pmem_rdata,
    output cache_pkg::line_t   pmem_wdata,
    input  logic               pmem_resp
);

    import cache_pkg::*;

    cache_addr_u cpu_addr;
    cache_addr_u pmem_addr;
    line_t       victim_line;
    line_t       fill_line;
    logic        pmem_start_read;
    logic        pmem_start_write;
    logic        pmem_done;

    assign cpu_addr.word = mem_address;

    cache_ctrl_if ctl_if ();

    cache_control u_control (
        .clk              (clk),
        .arst_n           (arst_n),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_cancel       (mem_cancel),
        .mem_resp         (mem_resp),
        .pmem_start_read  (pmem_start_read),
        .pmem_start_write (pmem_start_write),
        .pmem_done        (pmem_done),
        .ctl              (ctl_if.ctrl)
    );

    cache_datapath u_datapath (
        .clk         (clk),
        .arst_n      (arst_n),
        .address     (cpu_addr),
        .byte_enable (mem_byte_enable),
        .cpu_wdata   (mem_wdata),
        .cpu_rdata   (mem_rdata),
        .fill_line   (fill_line),
        .victim_line (victim_line),
        .pmem_addr   (pmem_addr),
        .ctl         (ctl_if.dp)
    );

    pmem_port u_pmem_port (
        .clk          (clk),
        .arst_n       (arst_n),
        .start_read   (pmem_start_read),
        .start_write  (pmem_start_write),
        .done         (pmem_done),
        .addr         (pmem_addr),
        .wline        (victim_line),
        .fill_line    (fill_line),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

endmodule : cache

//--- hdl/cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         mem_read,
    input  logic         mem_write,
    input  logic         mem_cancel,
    output logic         mem_resp,
    output logic         pmem_start_read,
    output logic         pmem_start_write,
    input  logic         pmem_done,
    cache_ctrl_if.ctrl   ctl
);

    import cache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_n;
    logic        pending;   // cpu still waits for an answer.
    logic        resp_ok;

    assign resp_ok = pending && !mem_cancel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= idle;
            pending <= 1'b0;
        end else begin
            state <= state_n;
            if (state == idle) begin
                pending <= (mem_read || mem_write) && !mem_cancel;
            end else if (mem_cancel) begin
                pending <= 1'b0;
            end
        end
    end

    always_comb begin
        state_n              = state;
        mem_resp             = 1'b0;
        pmem_start_read      = 1'b0;
        pmem_start_write     = 1'b0;
        ctl.load_tag         = 1'b0;
        ctl.load_data        = 1'b0;
        ctl.data_from_mem    = 1'b0;
        ctl.set_dirty        = 1'b0;
        ctl.clear_dirty      = 1'b0;
        ctl.lru_update       = 1'b0;
        ctl.use_victim_addr  = 1'b0;
        ctl.capture_addr     = 1'b0;
        unique case (state)
            idle: begin
                ctl.capture_addr = 1'b1;
                if ((mem_read || mem_write) && !mem_cancel) state_n = compare;
            end
            compare: begin
                if (!resp_ok) begin
                    state_n = idle;   // withdrawn before any traffic.
                end else if (ctl.hit) begin
                    mem_resp       = 1'b1;
                    ctl.lru_update = 1'b1;
                    if (mem_write) begin
                        ctl.load_data = 1'b1;
                        ctl.set_dirty = 1'b1;
                    end
                    state_n = idle;
                end else if (ctl.victim_dirty) begin
                    ctl.use_victim_addr = 1'b1;
                    pmem_start_write    = 1'b1;
                    state_n             = writeback;
                end else begin
                    pmem_start_read = 1'b1;
                    state_n         = fill;
                end
            end
            writeback: begin
                if (pmem_done) begin
                    pmem_start_read = 1'b1;
                    state_n         = fill;
                end
            end
            fill: if (pmem_done) state_n = refill_done;
            refill_done: begin
                // victim way still selected, tag not yet matching.
                ctl.load_tag      = 1'b1;
                ctl.load_data     = 1'b1;
                ctl.data_from_mem = 1'b1;
                ctl.clear_dirty   = 1'b1;
                state_n           = resp_ok ? compare : idle;
            end
            default: state_n = idle;
        endcase
    end

endmodule : cache_control

//--- hdl/cache_ctrl_if.sv
`timescale 1ns/1ps

interface cache_ctrl_if;

    logic load_tag;        // tag and valid into chosen way.
    logic load_data;
    logic data_from_mem;   // fill buffer instead of merged cpu line.
    logic set_dirty;
    logic clear_dirty;
    logic lru_update;
    logic use_victim_addr;
    logic capture_addr;    // latch request address.

    logic hit;
    logic victim_dirty;
    logic hit_way;

    modport ctrl (
        output load_tag, load_data, data_from_mem, set_dirty, clear_dirty,
        output lru_update, use_victim_addr, capture_addr,
        input  hit, victim_dirty, hit_way
    );

    modport dp (
        input  load_tag, load_data, data_from_mem, set_dirty, clear_dirty,
        input  lru_update, use_victim_addr, capture_addr,
        output hit, victim_dirty, hit_way
    );

endinterface : cache_ctrl_if

//--- hdl/cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cache_pkg::cache_addr_u   address,
    input  logic [cache_pkg::s_mask-1:0] byte_enable,
    input  cache_pkg::line_t         cpu_wdata,
    output cache_pkg::line_t         cpu_rdata,
    input  cache_pkg::line_t         fill_line,
    output cache_pkg::line_t         victim_line,
    output cache_pkg::cache_addr_u   pmem_addr,
    cache_ctrl_if.dp                 ctl
);

    import cache_pkg::*;

    logic [s_tag-1:0]         tag_arr  [2][num_sets];
    line_t                    data_arr [2][num_sets];
    logic [1:0][num_sets-1:0] valid;
    logic [1:0][num_sets-1:0] dirty;
    logic [num_sets-1:0]      lru;      // most recently used way.

    cache_addr_u          req_addr;
    logic [s_index-1:0]   idx;
    logic                 hit0;
    logic                 hit1;
    logic                 victim_way;
    logic                 way_sel;
    line_t                way_line;
    line_t                merged;
    line_t                data_in;

    assign idx  = req_addr.f.index;
    assign hit0 = valid[0][idx] && (tag_arr[0][idx] == req_addr.f.tag);
    assign hit1 = valid[1][idx] && (tag_arr[1][idx] == req_addr.f.tag);

    assign ctl.hit     = hit0 || hit1;
    assign ctl.hit_way = hit1;

    // invalid ways go first.
    always_comb begin
        if (!valid[0][idx]) victim_way = 1'b0;
        else if (!valid[1][idx]) victim_way = 1'b1;
        else victim_way = ~lru[idx];
    end

    assign ctl.victim_dirty = valid[victim_way][idx] && dirty[victim_way][idx];
    assign way_sel          = ctl.hit ? ctl.hit_way : victim_way;

    assign cpu_rdata   = data_arr[ctl.hit_way][idx];
    assign victim_line = data_arr[victim_way][idx];
    assign way_line    = data_arr[way_sel][idx];

    always_comb begin
        for (int b = 0; b < s_mask; b++) begin
            merged[8*b +: 8] = byte_enable[b] ? cpu_wdata[8*b +: 8] : way_line[8*b +: 8];
        end
    end

    assign data_in = ctl.data_from_mem ? fill_line : merged;

    always_comb begin
        pmem_addr.f.tag    = ctl.use_victim_addr ? tag_arr[victim_way][idx] : req_addr.f.tag;
        pmem_addr.f.index  = idx;
        pmem_addr.f.offset = '0;   // line aligned.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_addr.word <= '0;
            valid         <= '0;
            dirty         <= '0;
            lru           <= '0;
        end else begin
            if (ctl.capture_addr) req_addr <= address;
            if (ctl.load_tag) valid[way_sel][idx] <= 1'b1;
            if (ctl.set_dirty) dirty[way_sel][idx] <= 1'b1;
            else if (ctl.clear_dirty) dirty[way_sel][idx] <= 1'b0;
            if (ctl.lru_update) lru[idx] <= way_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.load_tag) tag_arr[way_sel][idx] <= req_addr.f.tag;
        if (ctl.load_data) data_arr[way_sel][idx] <= data_in;
    end

endmodule : cache_datapath

//--- hdl/cache_pkg.sv
package cache_pkg;

    localparam int s_offset = 5;
    localparam int s_index  = 4;
    localparam int s_tag    = 32 - s_offset - s_index;
    localparam int num_sets = 2**s_index;
    localparam int s_mask   = 2**s_offset;
    localparam int s_line   = 8*s_mask;

    typedef logic [s_line-1:0] line_t;

    // lookup view of an address.
    typedef struct packed {
        logic [s_tag-1:0]    tag;
        logic [s_index-1:0]  index;
        logic [s_offset-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } cache_addr_u;

    typedef enum logic [2:0] {
        idle,
        compare,
        writeback,
        fill,
        refill_done
    } ctrl_state_e;

endpackage : cache_pkg

//--- hdl/pmem_port.sv
`timescale 1ns/1ps

module pmem_port (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start_read,
    input  logic                   start_write,
    output logic                   done,
    input  cache_pkg::cache_addr_u addr,
    input  cache_pkg::line_t       wline,
    output cache_pkg::line_t       fill_line,
    output logic [31:0]            pmem_address,
    output logic                   pmem_read,
    output logic                   pmem_write,
    output cache_pkg::line_t       pmem_wdata,
    input  cache_pkg::line_t       pmem_rdata,
    input  logic                   pmem_resp
);

    import cache_pkg::*;

    logic [31:0] addr_q;
    line_t       wdata_q;
    line_t       fill_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pmem_read  <= 1'b0;
            pmem_write <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if ((pmem_read || pmem_write) && pmem_resp) begin
                pmem_read  <= 1'b0;
                pmem_write <= 1'b0;
                done       <= 1'b1;
            end else begin
                if (start_read) pmem_read <= 1'b1;
                if (start_write) pmem_write <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_read || start_write) addr_q <= addr.word;
        if (start_write) wdata_q <= wline;
        if (pmem_read && pmem_resp) fill_q <= pmem_rdata;   // fill buffer.
    end

    assign pmem_address = addr_q;
    assign pmem_wdata   = wdata_q;
    assign fill_line    = fill_q;

endmodule : pmem_port
